//--- filelist.f
+incdir+include
rtl/piPkg.sv
rtl/ebusPkg.sv
rtl/piControl.sv
rtl/piPriority.sv
rtl/piHold.sv
rtl/piCycleTimer.sv
rtl/piTop.sv
testbench/piTb.sv

//--- testbench/piTb.sv
`include "pi_macros.svh"

module piTb;

  localparam int NumSteps  = 14;
  localparam int OpCono    = 0;
  localparam int OpRequest = 1;
  localparam int OpDismiss = 2;

  logic                 clk;
  logic                 TIM;
  logic                 conoPi;
  logic [`PI_CMD_W-1:0] cmdWord;
  piPkg::levelMaskT     ioReq;
  logic                 dismiss;
  logic                 xfer;
  ebusPkg::vectorT      ebusData;
  logic                 ebusDemand;
  piPkg::levelNumT      piLevel;
  logic                 piCycle;
  logic                 vectorValid;
  ebusPkg::vectorT      vector;
  piPkg::levelMaskT     holdMask;
  logic                 active;

  bit              answer;     // Bus responder sends xfer for this step
  ebusPkg::vectorT answerVec;
  piPkg::levelNumT seenLevel;  // Level presented while ebusDemand was high

  // Stimulus and expected values, one entry per step
  string                stepName[NumSteps];
  int                   stepOp[NumSteps];
  logic [`PI_CMD_W-1:0] stepCmd[NumSteps];
  piPkg::levelMaskT     stepReq[NumSteps], stepHold[NumSteps];
  ebusPkg::vectorT      stepVec[NumSteps];
  piPkg::levelNumT      stepLevel[NumSteps];  // 0 means no cycle expected
  bit                   stepAns[NumSteps], stepVv[NumSteps], stepAct[NumSteps];
  int                   fill = 0;

  piTop piTop_i (.*);

  function automatic piPkg::levelMaskT lvlBit(int n);
    piPkg::levelMaskT m;
    m = '0;
    m[n] = 1'b1;
    return m;
  endfunction

  function automatic logic [`PI_CMD_W-1:0] selBits(piPkg::levelMaskT m);
    return `PI_CMD_W'(m) << piPkg::CONO_MASK_LO;  // Level 1 lands on bit 11
  endfunction

  function automatic logic [`PI_CMD_W-1:0] ctlBit(int pos);
    return `PI_CMD_W'(1) << pos;
  endfunction

  task automatic addStep(string name, int op, logic [`PI_CMD_W-1:0] cmd,
                         piPkg::levelMaskT req, bit ans, ebusPkg::vectorT vec,
                         piPkg::levelNumT lvl, bit vv, piPkg::levelMaskT hold, bit act);
    stepName[fill]  = name;
    stepOp[fill]    = op;
    stepCmd[fill]   = cmd;
    stepReq[fill]   = req;
    stepAns[fill]   = ans;
    stepVec[fill]   = vec;
    stepLevel[fill] = lvl;
    stepVv[fill]    = vv;
    stepHold[fill]  = hold;
    stepAct[fill]   = act;
    fill++;
  endtask

  task automatic checkEq(string what, logic [31:0] expVal, logic [31:0] actVal);
    if (actVal !== expVal) begin
      $display("ERR %s expected %0h actual %0h", what, expVal, actVal);
      $display("=== FAIL ===");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic runStep(int k);
    bit              busSeen;
    bit              cycSeen;
    logic            vvAct;
    ebusPkg::vectorT vecAct;
    busSeen   = 1'b0;
    cycSeen   = 1'b0;
    vvAct     = 1'b0;
    vecAct    = '0;
    seenLevel = '0;
    answer    = stepAns[k];
    answerVec = stepVec[k];
    ioReq     = stepReq[k];   // Request lines stay at this value
    cmdWord   = stepCmd[k];
    conoPi    = stepOp[k] == OpCono;
    dismiss   = stepOp[k] == OpDismiss;
    @(posedge clk);
    #5;
    conoPi  = 1'b0;
    dismiss = 1'b0;
    // Long enough for a cycle that ends by timeout
    for (int n = 0; n < `PI_TIMEOUT + 6 && !cycSeen; n++) begin
      @(posedge clk);
      #5;
      busSeen |= ebusDemand | piCycle;
      if (piCycle) begin
        cycSeen = 1'b1;
        vvAct   = vectorValid;
        vecAct  = vector;
      end
    end
    if (cycSeen) begin
      @(posedge clk);  // Hold bit is set at the end of DONE
      #5;
    end
    checkEq({stepName[k], " piCycle"}, stepLevel[k] != '0, cycSeen);
    checkEq({stepName[k], " ebusDemand"}, stepLevel[k] != '0, busSeen);
    if (stepLevel[k] != '0) begin
      checkEq({stepName[k], " piLevel"}, stepLevel[k], seenLevel);
      checkEq({stepName[k], " vectorValid"}, stepVv[k], vvAct);
      if (stepVv[k]) begin
        checkEq({stepName[k], " vector"}, stepVec[k], vecAct);
      end
    end
    checkEq({stepName[k], " holdMask"}, stepHold[k], holdMask);
    checkEq({stepName[k], " active"}, stepAct[k], active);
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Device side of the bus that answers on the third cycle of demand
  initial begin : busResponder
    int demandCnt;
    xfer      = 1'b0;
    ebusData  = '0;
    demandCnt = 0;
    forever begin
      @(posedge clk);
      #5;
      xfer = 1'b0;
      if (ebusDemand) begin
        demandCnt++;
        seenLevel = piLevel;
        if (answer && demandCnt == 3) begin
          xfer     = 1'b1;
          ebusData = answerVec;
        end
      end else begin
        demandCnt = 0;
      end
    end
  end

  initial begin
    #(NumSteps * (`PI_TIMEOUT + 10) * 40);
    $display("Watchdog expired, a test step never completed");
    $display("=== FAIL ===");
    $fatal(1, "Simulation hung");
  end

  initial begin
    TIM     = 1'b1;
    conoPi  = 1'b0;
    cmdWord = '0;
    ioReq   = '0;
    dismiss = 1'b0;
    addStep("onAct3", OpCono, ctlBit(piPkg::CONO_ON_SET) | ctlBit(piPkg::CONO_ACT) |
            selBits(lvlBit(3)), '0, 0, '0, 0, 0, '0, 1);
    addStep("on1and5", OpCono, ctlBit(piPkg::CONO_ON_SET) | selBits(lvlBit(1) | lvlBit(5)),
            '0, 0, '0, 0, 0, '0, 1);
    addStep("req3", OpRequest, '0, lvlBit(3), 1, 16'h0103, 3, 1, lvlBit(3), 1);
    addStep("req5Blocked", OpRequest, '0, lvlBit(5), 0, '0, 0, 0, lvlBit(3), 1);
    addStep("req1Wins", OpRequest, '0, lvlBit(1) | lvlBit(5), 1, 16'h0101, 1, 1,
            lvlBit(1) | lvlBit(3), 1);
    addStep("dismiss1", OpDismiss, '0, lvlBit(5), 0, '0, 0, 0, lvlBit(3), 1);
    addStep("dismiss3", OpDismiss, '0, lvlBit(5), 1, 16'h0105, 5, 1, lvlBit(5), 1);
    addStep("timeout1", OpRequest, '0, lvlBit(1), 0, '0, 1, 0, lvlBit(1) | lvlBit(5), 1);
    addStep("dismissT1", OpDismiss, '0, '0, 0, '0, 0, 0, lvlBit(5), 1);
    addStep("dismissT5", OpDismiss, '0, '0, 0, '0, 0, 0, '0, 1);
    addStep("gen6", OpCono, ctlBit(piPkg::CONO_GEN_SET) | selBits(lvlBit(6)), '0, 1,
            16'h0106, 6, 1, lvlBit(6), 1);
    addStep("sysClr", OpCono, ctlBit(piPkg::CONO_SYS_CLR), '0, 0, '0, 0, 0, '0, 0);
    addStep("reqAfterClr", OpRequest, '0, lvlBit(3), 1, '0, 0, 0, '0, 0);
    addStep("reOn3", OpCono, ctlBit(piPkg::CONO_ON_SET) | ctlBit(piPkg::CONO_ACT) |
            selBits(lvlBit(3)), lvlBit(3), 1, 16'h0203, 3, 1, lvlBit(3), 1);
    repeat (3) @(posedge clk);
    #5;
    TIM = 1'b0;
    for (int k = 0; k < NumSteps; k++) begin
      runStep(k);
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- rtl/piTop.sv
`include "pi_macros.svh"

module piTop (
  input  logic                 clk,
  input  logic                 TIM,
  input  logic                 conoPi,
  input  logic [`PI_CMD_W-1:0] cmdWord,
  input  piPkg::levelMaskT     ioReq,
  input  logic                 dismiss,
  input  logic                 xfer,
  input  ebusPkg::vectorT      ebusData,
  output logic                 ebusDemand,
  output piPkg::levelNumT      piLevel,
  output logic                 piCycle,
  output logic                 vectorValid,
  output ebusPkg::vectorT      vector,
  output piPkg::levelMaskT     holdMask,
  output logic                 active
);

  piPkg::levelMaskT onMask;
  piPkg::levelMaskT genMask;
  logic             sysClr;
  logic             reqValid;
  piPkg::levelNumT  reqLevel;
  logic             setPih;
  piPkg::levelNumT  cycLevel;

  piControl piControl_i (
    .clk     (clk),
    .TIM     (TIM),
    .conoPi  (conoPi),
    .cmdWord (cmdWord),
    .onMask  (onMask),
    .genMask (genMask),
    .active  (active),
    .sysClr  (sysClr)
  );

  piPriority piPriority_i (
    .clk      (clk),
    .TIM      (TIM),
    .ioReq    (ioReq),
    .onMask   (onMask),
    .genMask  (genMask),
    .active   (active),
    .holdMask (holdMask),
    .reqValid (reqValid),
    .reqLevel (reqLevel)
  );

  piHold piHold_i (
    .clk      (clk),
    .TIM      (TIM),
    .sysClr   (sysClr),
    .setPih   (setPih),
    .cycLevel (cycLevel),
    .dismiss  (dismiss),
    .holdMask (holdMask)
  );

  piCycleTimer piCycleTimer_i (
    .clk         (clk),
    .TIM         (TIM),
    .sysClr      (sysClr),
    .reqValid    (reqValid),
    .reqLevel    (reqLevel),
    .xfer        (xfer),
    .ebusData    (ebusData),
    .ebusDemand  (ebusDemand),
    .piLevel     (piLevel),
    .cycLevel    (cycLevel),
    .setPih      (setPih),
    .piCycle     (piCycle),
    .vectorValid (vectorValid),
    .vector      (vector)
  );

endmodule

//--- rtl/piCycleTimer.sv
`include "pi_macros.svh"

module piCycleTimer (
  input  logic             clk,
  input  logic             TIM,
  input  logic             sysClr,
  input  logic             reqValid,
  input  piPkg::levelNumT  reqLevel,
  input  logic             xfer,
  input  ebusPkg::vectorT  ebusData,
  output logic             ebusDemand,
  output piPkg::levelNumT  piLevel,
  output piPkg::levelNumT  cycLevel,
  output logic             setPih,
  output logic             piCycle,
  output logic             vectorValid,
  output ebusPkg::vectorT  vector
);

  localparam int CntW = $clog2(`PI_TIMEOUT + 1);

  ebusPkg::cycStateT state;
  logic [CntW-1:0]   waitCnt;
  logic              gotVec;   // Transfer seen during WAIT
  logic              timedOut;

  assign timedOut = waitCnt == CntW'(`PI_TIMEOUT - 1);

  always_ff @(posedge clk or posedge TIM) begin
    if (TIM) begin
      state    <= ebusPkg::IDLE;
      cycLevel <= '0;
      waitCnt  <= '0;
      gotVec   <= 1'b0;
      vector   <= '0;
    end else if (sysClr) begin
      state   <= ebusPkg::IDLE;
      waitCnt <= '0;
      gotVec  <= 1'b0;
    end else begin
      case (state)
        ebusPkg::IDLE: begin
          if (reqValid) begin
            cycLevel <= reqLevel;
            state    <= ebusPkg::DEMAND;
          end
        end
        ebusPkg::DEMAND: begin
          waitCnt <= '0;
          gotVec  <= 1'b0;
          state   <= ebusPkg::WAIT;
        end
        ebusPkg::WAIT: begin
          if (xfer) begin
            vector <= ebusData;
            gotVec <= 1'b1;
            state  <= ebusPkg::DONE;
          end else if (timedOut) begin
            state <= ebusPkg::DONE;  // No answer so the vector stays invalid
          end else begin
            waitCnt <= waitCnt + 1'b1;
          end
        end
        default: state <= ebusPkg::IDLE;  // DONE lasts one cycle
      endcase
    end
  end

  assign ebusDemand  = (state == ebusPkg::DEMAND) || (state == ebusPkg::WAIT);
  assign piLevel     = ebusDemand ? cycLevel : '0;
  assign piCycle     = state == ebusPkg::DONE;
  assign setPih      = piCycle;
  assign vectorValid = piCycle && gotVec;

  // Completion always closes a bus wait and is a single pulse
  apCycleEnd: assert property (@(posedge clk) disable iff (TIM)
    piCycle |-> $past(state == ebusPkg::WAIT) ##1 !piCycle);

  apDemandLevel: assert property (@(posedge clk) disable iff (TIM)
    ebusDemand |-> cycLevel != '0);

endmodule

//--- rtl/piHold.sv
`include "pi_macros.svh"

module piHold (
  input  logic             clk,
  input  logic             TIM,
  input  logic             sysClr,
  input  logic             setPih,
  input  piPkg::levelNumT  cycLevel,
  input  logic             dismiss,
  output piPkg::levelMaskT holdMask
);

  piPkg::levelNumT  topHeld;
  piPkg::levelMaskT setSel;
  piPkg::levelMaskT clrSel;

  assign topHeld = piPkg::topLevel(holdMask);

  // Level number to one-hot for the set and dismiss decoders
  always_comb begin
    setSel = '0;
    clrSel = '0;
    for (int i = 1; i <= `PI_LEVELS; i++) begin
      setSel[i] = setPih && (cycLevel == piPkg::levelNumT'(i));
      clrSel[i] = dismiss && (topHeld == piPkg::levelNumT'(i));
    end
  end

  always_ff @(posedge clk or posedge TIM) begin
    if (TIM) begin
      holdMask <= '0;
    end else if (sysClr) begin
      holdMask <= '0;
    end else begin
      holdMask <= (holdMask & ~clrSel) | setSel;
    end
  end

  // The cycle timer only serves levels that outrank everything held
  apSetFree: assert property (@(posedge clk) disable iff (TIM)
    setPih |-> (setSel & holdMask) == '0);

  apDismissHeld: assert property (@(posedge clk) disable iff (TIM)
    dismiss |-> holdMask != '0);

endmodule

//--- rtl/piPriority.sv
module piPriority (
  input  logic             clk,
  input  logic             TIM,
  input  piPkg::levelMaskT ioReq,
  input  piPkg::levelMaskT onMask,
  input  piPkg::levelMaskT genMask,
  input  logic             active,
  input  piPkg::levelMaskT holdMask,
  output logic             reqValid,
  output piPkg::levelNumT  reqLevel
);

  piPkg::levelMaskT pir;     // Registered pending levels
  piPkg::levelMaskT pirEn;
  piPkg::levelNumT  pirTop;
  piPkg::levelNumT  pihTop;
  logic             outranks;

  // Software request, or device request on a level that is on
  assign pirEn = active ? (genMask | (onMask & ioReq)) : '0;

  always_ff @(posedge clk or posedge TIM) begin
    if (TIM) begin
      pir <= '0;
    end else begin
      pir <= pirEn;
    end
  end

  // Encoders for the pending side and the held side
  always_comb begin
    pirTop = piPkg::topLevel(pir);
    pihTop = piPkg::topLevel(holdMask);
  end

  // Nothing held counts as below every level
  always_comb begin
    outranks = 1'b0;
    if (pirTop != '0) begin
      if (pihTop == '0) begin
        outranks = 1'b1;
      end else begin
        outranks = pirTop < pihTop;
      end
    end
  end

  assign reqValid = outranks;
  assign reqLevel = outranks ? pirTop : '0;

endmodule

//--- rtl/piControl.sv
`include "pi_macros.svh"

module piControl (
  input  logic                 clk,
  input  logic                 TIM,
  input  logic                 conoPi,
  input  logic [`PI_CMD_W-1:0] cmdWord,
  output piPkg::levelMaskT     onMask,
  output piPkg::levelMaskT     genMask,
  output logic                 active,
  output logic                 sysClr
);

  piPkg::levelMaskT sel;
  piPkg::levelMaskT onClrSel, onSetSel, genClrSel, genSetSel;
  piPkg::levelMaskT nextOn, nextGen;
  logic             nextActive;
  logic             clrCmd;

  assign sel    = cmdWord[piPkg::CONO_MASK_LO +: `PI_LEVELS];
  assign clrCmd = cmdWord[piPkg::CONO_SYS_CLR];

  always_comb begin
    onClrSel  = cmdWord[piPkg::CONO_ON_CLR]  ? sel : '0;
    onSetSel  = cmdWord[piPkg::CONO_ON_SET]  ? sel : '0;
    genClrSel = cmdWord[piPkg::CONO_GEN_CLR] ? sel : '0;
    genSetSel = cmdWord[piPkg::CONO_GEN_SET] ? sel : '0;

    // Clear first, then set
    nextOn  = (onMask & ~onClrSel) | onSetSel;
    nextGen = (genMask & ~genClrSel) | genSetSel;

    nextActive = active;
    if (cmdWord[piPkg::CONO_OFF]) nextActive = 1'b0;
    if (cmdWord[piPkg::CONO_ACT]) nextActive = 1'b1;  // ACT beats OFF
  end

  always_ff @(posedge clk or posedge TIM) begin
    if (TIM) begin
      onMask  <= '0;
      genMask <= '0;
      active  <= 1'b0;
      sysClr  <= 1'b0;
    end else begin
      sysClr <= conoPi & clrCmd;  // Pulse follows the command
      if (conoPi) begin
        if (clrCmd) begin
          onMask  <= '0;
          genMask <= '0;
          active  <= 1'b0;
        end else begin
          onMask  <= nextOn;
          genMask <= nextGen;
          active  <= nextActive;
        end
      end
    end
  end

endmodule

//--- rtl/ebusPkg.sv
`include "pi_macros.svh"

package ebusPkg;

  // Interrupt cycle on the external bus
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    DEMAND = 2'd1,  // Demand raised and level presented
    WAIT   = 2'd2,  // Waiting for xfer or timeout
    DONE   = 2'd3
  } cycStateT;

  typedef logic [`PI_VEC_W-1:0] vectorT;

endpackage

//--- rtl/piPkg.sv
`include "pi_macros.svh"

package piPkg;

  typedef logic [`PI_LEVELS:1] levelMaskT;              // Bit n is level n
  typedef logic [$clog2(`PI_LEVELS+1)-1:0] levelNumT;   // 0 means none

  // CONO word bit positions
  localparam int CONO_GEN_CLR = 4;
  localparam int CONO_SYS_CLR = 5;
  localparam int CONO_GEN_SET = 6;
  localparam int CONO_ON_SET  = 7;
  localparam int CONO_ON_CLR  = 8;
  localparam int CONO_OFF     = 9;
  localparam int CONO_ACT     = 10;
  localparam int CONO_MASK_LO = 11;  // Bits 11..17 select levels 1..7

  // Most urgent level set in a mask
  function automatic levelNumT topLevel(levelMaskT m);
    levelNumT n;
    n = '0;
    for (int i = `PI_LEVELS; i >= 1; i--) begin
      if (m[i]) begin
        n = levelNumT'(i);
      end
    end
    return n;
  endfunction

endpackage

//--- include/pi_macros.svh
`ifndef PI_MACROS_SVH
`define PI_MACROS_SVH

// Interrupt levels 1..7 with level 1 most urgent
`define PI_LEVELS 7

`define PI_CMD_W 18  // CONO word
`define PI_VEC_W 16  // Vector word carried by the transfer strobe

// Wait cycles before a bus interrupt cycle is abandoned
`define PI_TIMEOUT 12

`endif
